//--- rtl/rdmx_pkg.sv
// Shared widths, write-port constants, sequencer phase codes
// and the two-view write data word
`default_nettype none

package rdmx_pkg;

    // --------------------------------------------------
    // Write port geometry
    // --------------------------------------------------
    localparam int data_w     = 64;
    localparam int strb_w     = 8;
    localparam int addr_w     = 64;
    localparam int beat_bytes = 8;

    // Configuration and counter widths
    localparam int pkt_w = 16;
    localparam int frm_w = 32;
    localparam int cnt_w = 32;
    localparam int len_w = 8;

    // One metadata ring entry is two beats
    localparam int md_step = 16;

    // Frame counter beat only writes the low four bytes
    localparam logic [strb_w-1:0] fc_strb = 8'h0F;

    // --------------------------------------------------
    // Sequencer phases
    // --------------------------------------------------
    typedef enum logic [2:0] {
        ph_reset = 3'd0,
        ph_start = 3'd1,
        ph_fd    = 3'd2,
        ph_md1   = 3'd3,
        ph_md2   = 3'd4,
        ph_fc    = 3'd5
    } phase_t;

    // --------------------------------------------------
    // Write data word
    // --------------------------------------------------
    // Raw stream word, or counter layout with
    // fc[1] as zero pad and fc[0] as the frame count
    typedef union packed {
        logic [data_w-1:0]      raw;
        logic [1:0][cnt_w-1:0]  fc;
    } word_u;

endpackage

`default_nettype wire

//--- rtl/md_capture.sv
// Two-beat metadata capture buffer
`timescale 1ns/1ps
`default_nettype none

module md_capture
    import rdmx_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic [data_w-1:0]   md_tdata,
    input  logic                md_tvalid,
    output logic                md_tready,
    input  logic                md_release,
    output logic [data_w-1:0]   md_word0,
    output logic [data_w-1:0]   md_word1,
    output logic                md_full
);

    // Low selects md_word0 for the next beat, high selects md_word1
    logic fill_sel;
    // Goes high on the first edge out of reset
    logic armed;
    logic md_hs;

    // Accept beats only when running and not holding a full entry
    assign md_tready = armed & ~md_full;
    assign md_hs     = md_tvalid & md_tready;

    // --------------------------------------------------
    // Fill control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            armed    <= 1'b0;
            fill_sel <= 1'b0;
            md_full  <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (md_release) begin
                // Entry written out, open for the next frame
                md_full <= 1'b0;
            end else if (md_hs) begin
                if (fill_sel) begin
                    md_full <= 1'b1;
                end
                fill_sel <= ~fill_sel;
            end
        end
    end

    // Payload words
    always_ff @(posedge clk) begin
        if (md_hs && !fill_sel) begin
            md_word0 <= md_tdata;
        end
        if (md_hs && fill_sel) begin
            md_word1 <= md_tdata;
        end
    end

endmodule

`default_nettype wire

//--- rtl/frame_sequencer.sv
// Phase FSM for frame data, metadata and frame counter writes
// Tracks beats, packets and frames on write handshakes
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer
    import rdmx_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic [pkt_w-1:0]    packet_size,
    input  logic [frm_w-1:0]    frame_size,
    input  logic                w_valid,
    input  logic                w_ready,
    input  logic                w_last,
    input  logic                md_full,
    output phase_t              phase,
    output logic                beat_first,
    output logic                burst_done,
    output logic [cnt_w-1:0]    frame_count,
    output logic                md_release
);

    logic [frm_w-1:0]   pkts_half;
    logic [cnt_w-1:0]   packet_count;
    logic               in_burst;
    logic               w_hs;
    logic               md_hs;

    // Write handshakes
    assign w_hs       = w_valid & w_ready;
    // Metadata beats move only once the buffer is loaded
    assign md_hs      = md_full & w_ready;
    assign burst_done = w_hs & w_last;
    assign beat_first = ~in_burst;

    // --------------------------------------------------
    // Packets per half frame
    // --------------------------------------------------
    // Frame size over packet size, halved again for the half frame
    always_comb begin
        case (packet_size)
            16'd8:    pkts_half = frame_size >> 4;
            16'd16:   pkts_half = frame_size >> 5;
            16'd32:   pkts_half = frame_size >> 6;
            16'd64:   pkts_half = frame_size >> 7;
            16'd128:  pkts_half = frame_size >> 8;
            16'd256:  pkts_half = frame_size >> 9;
            16'd512:  pkts_half = frame_size >> 10;
            16'd1024: pkts_half = frame_size >> 11;
            16'd2048: pkts_half = frame_size >> 12;
            16'd4096: pkts_half = frame_size >> 13;
            16'd8192: pkts_half = frame_size >> 14;
            // Unsupported size
            default:  pkts_half = 32'd1;
        endcase
    end

    // --------------------------------------------------
    // Phase FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase        <= ph_reset;
            in_burst     <= 1'b0;
            packet_count <= 32'd1;
            frame_count  <= 32'd1;
            md_release   <= 1'b0;
        end else begin
            // Single-cycle pulse
            md_release <= 1'b0;

            // Inside a burst after any beat that is not the last
            if (burst_done) begin
                in_burst <= 1'b0;
            end else if (w_hs) begin
                in_burst <= 1'b1;
            end

            case (phase)
                ph_reset: phase <= ph_start;
                ph_start: begin
                    in_burst     <= 1'b0;
                    packet_count <= 32'd1;
                    frame_count  <= 32'd1;
                    phase        <= ph_fd;
                end
                ph_fd: begin
                    if (burst_done) begin
                        if (packet_count == pkts_half) begin
                            phase <= ph_md1;
                        end else begin
                            packet_count <= packet_count + 32'd1;
                        end
                    end
                end
                ph_md1: begin
                    if (md_hs) begin
                        phase <= ph_md2;
                    end
                end
                ph_md2: begin
                    if (md_hs) begin
                        md_release <= 1'b1;
                        phase      <= ph_fc;
                    end
                end
                ph_fc: begin
                    if (w_hs) begin
                        frame_count  <= frame_count + 32'd1;
                        packet_count <= 32'd1;
                        phase        <= ph_fd;
                    end
                end
                default: phase <= ph_reset;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/ring_addr_gen.sv
// Ring pointers and burst address and length generation
`timescale 1ns/1ps
`default_nettype none

module ring_addr_gen
    import rdmx_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  phase_t              phase,
    input  logic                burst_done,
    input  logic [pkt_w-1:0]    packet_size,
    input  logic [addr_w-1:0]   fd_ring_addr,
    input  logic [addr_w-1:0]   fd_ring_size,
    input  logic [addr_w-1:0]   md_ring_addr,
    input  logic [addr_w-1:0]   md_ring_size,
    input  logic [addr_w-1:0]   fc_addr,
    output logic [addr_w-1:0]   aw_addr,
    output logic [len_w-1:0]    aw_len
);

    // Offsets of the next free slot in each ring
    logic [addr_w-1:0]  fd_ptr;
    logic [addr_w-1:0]  md_ptr;
    logic [addr_w-1:0]  fd_next;
    logic [addr_w-1:0]  md_next;
    // Beats per packet minus one
    logic [pkt_w-1:0]   fd_len;

    assign fd_next = fd_ptr + {{(addr_w-pkt_w){1'b0}}, packet_size};
    assign md_next = md_ptr + addr_w'(md_step);
    assign fd_len  = packet_size / pkt_w'(beat_bytes) - 16'd1;

    // --------------------------------------------------
    // Pointer update
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn || phase == ph_start) begin
            fd_ptr <= '0;
            md_ptr <= '0;
        end else if (burst_done) begin
            // Wrap when the next slot reaches the ring size
            if (phase == ph_fd) begin
                fd_ptr <= (fd_next < fd_ring_size) ? fd_next : '0;
            end
            if (phase == ph_md2) begin
                md_ptr <= (md_next < md_ring_size) ? md_next : '0;
            end
        end
    end

    // Address and length for the current phase
    always_comb begin
        case (phase)
            ph_fd: begin
                aw_addr = fd_ring_addr + fd_ptr;
                aw_len  = fd_len[len_w-1:0];
            end
            ph_md1, ph_md2: begin
                aw_addr = md_ring_addr + md_ptr;
                aw_len  = 8'd1;
            end
            ph_fc: begin
                aw_addr = fc_addr;
                aw_len  = 8'd0;
            end
            default: begin
                aw_addr = '0;
                aw_len  = 8'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/write_mux.sv
// Write beat selection per phase, stream ready and address strobe
`timescale 1ns/1ps
`default_nettype none

module write_mux
    import rdmx_pkg::*;
(
    input  phase_t              phase,
    input  logic                beat_first,
    input  logic                w_ready,
    input  logic [data_w-1:0]   fd_tdata,
    input  logic                fd_tvalid,
    input  logic                fd_tlast,
    output logic                fd_tready,
    input  logic [data_w-1:0]   md_word0,
    input  logic [data_w-1:0]   md_word1,
    input  logic                md_full,
    input  logic [cnt_w-1:0]    frame_count,
    output word_u               w_data,
    output logic [strb_w-1:0]   w_strb,
    output logic                w_last,
    output logic                w_valid,
    output logic                aw_valid
);

    // Stream passes straight through in the frame-data phase
    assign fd_tready = (phase == ph_fd) & w_ready;

    // Counter beat writes only the low word
    assign w_strb = (phase == ph_fc) ? fc_strb : '1;

    // --------------------------------------------------
    // Data, last and valid per phase
    // --------------------------------------------------
    always_comb begin
        w_data.raw = '0;
        w_last     = 1'b0;
        w_valid    = 1'b0;
        case (phase)
            ph_fd: begin
                w_data.raw = fd_tdata;
                w_last     = fd_tlast;
                w_valid    = fd_tvalid;
            end
            ph_md1: begin
                w_data.raw = md_word0;
                w_valid    = md_full;
            end
            ph_md2: begin
                w_data.raw = md_word1;
                w_last     = 1'b1;
                w_valid    = md_full;
            end
            ph_fc: begin
                // Pad stays zero above the count
                w_data.fc[0] = frame_count;
                w_last       = 1'b1;
                w_valid      = 1'b1;
            end
            default: ;
        endcase
    end

    // One-cycle address strobe with the first accepted beat
    // The second metadata beat continues the md1 burst
    assign aw_valid = beat_first & w_valid & w_ready & (phase != ph_md2);

endmodule

`default_nettype wire

//--- rtl/rdmx_shim_top.sv
// Frame-data shim top level
// Connects metadata capture, sequencer, address generator and write mux
`timescale 1ns/1ps
`default_nettype none

module rdmx_shim_top
    import rdmx_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,

    // Runtime configuration, steady while out of reset
    input  logic [pkt_w-1:0]    packet_size,
    input  logic [frm_w-1:0]    frame_size,
    input  logic [addr_w-1:0]   fd_ring_addr,
    input  logic [addr_w-1:0]   fd_ring_size,
    input  logic [addr_w-1:0]   md_ring_addr,
    input  logic [addr_w-1:0]   md_ring_size,
    input  logic [addr_w-1:0]   fc_addr,

    // Frame-data stream
    input  logic [data_w-1:0]   fd_tdata,
    input  logic                fd_tvalid,
    input  logic                fd_tlast,
    output logic                fd_tready,

    // Metadata stream
    input  logic [data_w-1:0]   md_tdata,
    input  logic                md_tvalid,
    output logic                md_tready,

    // Write port
    output logic [addr_w-1:0]   aw_addr,
    output logic [len_w-1:0]    aw_len,
    output logic                aw_valid,
    output logic [data_w-1:0]   w_data,
    output logic [strb_w-1:0]   w_strb,
    output logic                w_last,
    output logic                w_valid,
    input  logic                w_ready
);

    // Sequencer outputs
    phase_t             phase;
    logic               beat_first;
    logic               burst_done;
    logic [cnt_w-1:0]   frame_count;
    logic               md_release;

    // Metadata holding buffer
    logic [data_w-1:0]  md_word0;
    logic [data_w-1:0]  md_word1;
    logic               md_full;

    md_capture u_md_capture (
        .clk        (clk),
        .resetn     (resetn),
        .md_tdata   (md_tdata),
        .md_tvalid  (md_tvalid),
        .md_tready  (md_tready),
        .md_release (md_release),
        .md_word0   (md_word0),
        .md_word1   (md_word1),
        .md_full    (md_full)
    );

    frame_sequencer u_frame_sequencer (
        .clk         (clk),
        .resetn      (resetn),
        .packet_size (packet_size),
        .frame_size  (frame_size),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w_last      (w_last),
        .md_full     (md_full),
        .phase       (phase),
        .beat_first  (beat_first),
        .burst_done  (burst_done),
        .frame_count (frame_count),
        .md_release  (md_release)
    );

    ring_addr_gen u_ring_addr_gen (
        .clk          (clk),
        .resetn       (resetn),
        .phase        (phase),
        .burst_done   (burst_done),
        .packet_size  (packet_size),
        .fd_ring_addr (fd_ring_addr),
        .fd_ring_size (fd_ring_size),
        .md_ring_addr (md_ring_addr),
        .md_ring_size (md_ring_size),
        .fc_addr      (fc_addr),
        .aw_addr      (aw_addr),
        .aw_len       (aw_len)
    );

    write_mux u_write_mux (
        .phase       (phase),
        .beat_first  (beat_first),
        .w_ready     (w_ready),
        .fd_tdata    (fd_tdata),
        .fd_tvalid   (fd_tvalid),
        .fd_tlast    (fd_tlast),
        .fd_tready   (fd_tready),
        .md_word0    (md_word0),
        .md_word1    (md_word1),
        .md_full     (md_full),
        .frame_count (frame_count),
        .w_data      (w_data),
        .w_strb      (w_strb),
        .w_last      (w_last),
        .w_valid     (w_valid),
        .aw_valid    (aw_valid)
    );

endmodule

`default_nettype wire

//--- tb/rdmx_checker.sv
// Write port checker with the reference burst sequence
// and per-test result lines
`timescale 1ns/1ps
`default_nettype none

module rdmx_checker
    import rdmx_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic [pkt_w-1:0]    packet_size,
    input  logic [frm_w-1:0]    frame_size,
    input  logic [addr_w-1:0]   fd_ring_addr,
    input  logic [addr_w-1:0]   fd_ring_size,
    input  logic [addr_w-1:0]   md_ring_addr,
    input  logic [addr_w-1:0]   md_ring_size,
    input  logic [addr_w-1:0]   fc_addr,
    input  logic                fd_tready,
    input  logic                md_tready,
    input  logic [addr_w-1:0]   aw_addr,
    input  logic [7:0]          aw_len,
    input  logic                aw_valid,
    input  logic [data_w-1:0]   w_data,
    input  logic [strb_w-1:0]   w_strb,
    input  logic                w_last,
    input  logic                w_valid,
    input  logic                w_ready,
    output logic                all_seen,
    output logic [31:0]         n_pass,
    output logic [31:0]         n_fail
);

    // Expected beats in write order
    logic [data_w-1:0]  exp_data  [$];
    logic [strb_w-1:0]  exp_strb  [$];
    logic               exp_last  [$];
    logic               exp_first [$];
    logic [addr_w-1:0]  exp_addr  [$];
    logic [7:0]         exp_len   [$];

    string  cur_name;
    int     n_halves;
    int     beat_idx;
    int     n_err;
    logic   active;
    logic   built;
    // Reset level at the previous falling edge
    logic   prev_resetn;

    initial begin
        active      = 1'b0;
        built       = 1'b0;
        prev_resetn = 1'b0;
        all_seen    = 1'b0;
        n_pass      = '0;
        n_fail      = '0;
    end

    // --------------------------------------------------
    // Data rules for the streams
    // --------------------------------------------------
    function automatic logic [data_w-1:0] fd_word(input int h, input int p, input int b);
        fd_word = {8'hFD, h[7:0], p[15:0], b[15:0], 16'h5A3C ^ b[15:0]};
    endfunction

    function automatic logic [data_w-1:0] md_word(input int h, input int k);
        md_word = {8'h3D, k[7:0], h[15:0], ~h[31:0]};
    endfunction

    function automatic void add_beat(input logic [data_w-1:0] data, input logic [7:0] strb,
                                     input logic last, input logic first,
                                     input logic [addr_w-1:0] addr, input logic [7:0] len);
        exp_data.push_back(data);
        exp_strb.push_back(strb);
        exp_last.push_back(last);
        exp_first.push_back(first);
        exp_addr.push_back(addr);
        exp_len.push_back(len);
    endfunction

    // Reference sequence of bursts for the current configuration
    function automatic void build_reference();
        int                 pkts_half;
        int                 bpp;
        int                 h;
        int                 p;
        int                 b;
        logic [31:0]        count;
        logic [addr_w-1:0]  fd_ptr;
        logic [addr_w-1:0]  md_ptr;
        pkts_half = frame_size / packet_size / 2;
        bpp       = packet_size / beat_bytes;
        fd_ptr    = '0;
        md_ptr    = '0;
        for (h = 0; h < n_halves; h++) begin
            for (p = 0; p < pkts_half; p++) begin
                for (b = 0; b < bpp; b++) begin
                    add_beat(fd_word(h, p, b), 8'hFF, b == bpp - 1, b == 0,
                             fd_ring_addr + fd_ptr, bpp - 1);
                end
                // Slot that would reach the ring size wraps to the start
                fd_ptr = fd_ptr + packet_size;
                if (fd_ptr >= fd_ring_size) begin
                    fd_ptr = '0;
                end
            end
            // Metadata pair as one two-beat burst
            add_beat(md_word(h, 0), 8'hFF, 1'b0, 1'b1, md_ring_addr + md_ptr, 8'd1);
            add_beat(md_word(h, 1), 8'hFF, 1'b1, 1'b0, md_ring_addr + md_ptr, 8'd1);
            md_ptr = md_ptr + md_step;
            if (md_ptr >= md_ring_size) begin
                md_ptr = '0;
            end
            // Counter counts half frames from 1, low four bytes only
            count = h + 1;
            add_beat({32'd0, count}, 8'h0F, 1'b1, 1'b1, fc_addr, 8'd0);
        end
    endfunction

    task automatic report_failure(input string what);
        $display("%s: %s", cur_name, what);
        n_err++;
    endtask

    task automatic compare_value(input string field, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
        if (exp_val !== act_val) begin
            $display("mismatch %s beat %0d %s: expected %h actual %h",
                     cur_name, beat_idx, field, exp_val, act_val);
            n_err++;
        end
    endtask

    task automatic start_test(input string name, input int halves);
        cur_name = name;
        n_halves = halves;
        beat_idx = 0;
        n_err    = 0;
        built    = 1'b0;
        all_seen = 1'b0;
        // Each test starts from an empty expected sequence
        exp_data.delete();
        exp_strb.delete();
        exp_last.delete();
        exp_first.delete();
        exp_addr.delete();
        exp_len.delete();
        active   = 1'b1;
    endtask

    task automatic end_test();
        if (beat_idx < exp_data.size()) begin
            report_failure("write sequence stopped before all expected beats");
        end
        if (n_err == 0) begin
            n_pass++;
            $display("test %s: passed, %0d beats checked", cur_name, beat_idx);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", cur_name, n_err);
        end
        active   = 1'b0;
        all_seen = 1'b0;
    endtask

    // --------------------------------------------------
    // Compare on the falling edge, where the port is stable
    // --------------------------------------------------
    always @(negedge clk) begin
        // In reset after its first edge, or the first cycle after release
        if (active && !prev_resetn) begin
            if (w_valid) report_failure("w_valid high in reset or the cycle after");
            if (aw_valid) report_failure("aw_valid high in reset or the cycle after");
            if (fd_tready) report_failure("fd_tready high in reset or the cycle after");
            if (md_tready) report_failure("md_tready high in reset or the cycle after");
        end
        // Configuration is settled once reset is released
        if (active && resetn && !prev_resetn) begin
            build_reference();
            built = 1'b1;
        end
        if (active && built && resetn) begin
            if (w_valid && w_ready) begin
                if (beat_idx >= exp_data.size()) begin
                    report_failure("write beat after the end of the expected sequence");
                end else begin
                    compare_value("w_data", exp_data[beat_idx], w_data);
                    compare_value("w_strb", exp_strb[beat_idx], w_strb);
                    compare_value("w_last", exp_last[beat_idx], w_last);
                    compare_value("aw_valid", exp_first[beat_idx], aw_valid);
                    if (exp_first[beat_idx]) begin
                        compare_value("aw_addr", exp_addr[beat_idx], aw_addr);
                        compare_value("aw_len", exp_len[beat_idx], aw_len);
                    end
                end
                beat_idx++;
            end else if (aw_valid) begin
                report_failure("aw_valid high without a write handshake");
            end
        end
        prev_resetn = resetn;
        all_seen    = active && built && (beat_idx >= exp_data.size());
    end

endmodule

`default_nettype wire

//--- tb/tb_rdmx_shim.sv
// Testbench top for the frame-data shim
// Clock, reset, configuration, stream stimulus, back-pressure and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_rdmx_shim
    import rdmx_pkg::*;
();

    localparam int num_tests = 6;

    logic               clk;
    logic               resetn;

    // Configuration
    logic [pkt_w-1:0]   packet_size;
    logic [frm_w-1:0]   frame_size;
    logic [addr_w-1:0]  fd_ring_addr;
    logic [addr_w-1:0]  fd_ring_size;
    logic [addr_w-1:0]  md_ring_addr;
    logic [addr_w-1:0]  md_ring_size;
    logic [addr_w-1:0]  fc_addr;

    // Streams
    logic [data_w-1:0]  fd_tdata;
    logic               fd_tvalid;
    logic               fd_tlast;
    logic               fd_tready;
    logic [data_w-1:0]  md_tdata;
    logic               md_tvalid;
    logic               md_tready;

    // Write port
    logic [addr_w-1:0]  aw_addr;
    logic [len_w-1:0]   aw_len;
    logic               aw_valid;
    logic [data_w-1:0]  w_data;
    logic [strb_w-1:0]  w_strb;
    logic               w_last;
    logic               w_valid;
    logic               w_ready;

    // Checker status
    logic               chk_done;
    logic [31:0]        n_pass;
    logic [31:0]        n_fail;

    // Test table
    string  t_name   [num_tests];
    int     t_pkt    [num_tests];
    int     t_frm    [num_tests];
    int     t_fd_sz  [num_tests];
    int     t_md_sz  [num_tests];
    int     t_halves [num_tests];
    bit     t_holes  [num_tests];

    int limit = 0;
    int cycles;
    int total_beats;
    int seed;
    int ti;

    rdmx_shim_top u_rdmx_shim_top (
        .clk (clk), .resetn (resetn),
        .packet_size (packet_size), .frame_size (frame_size),
        .fd_ring_addr (fd_ring_addr), .fd_ring_size (fd_ring_size),
        .md_ring_addr (md_ring_addr), .md_ring_size (md_ring_size),
        .fc_addr (fc_addr),
        .fd_tdata (fd_tdata), .fd_tvalid (fd_tvalid), .fd_tlast (fd_tlast),
        .fd_tready (fd_tready),
        .md_tdata (md_tdata), .md_tvalid (md_tvalid), .md_tready (md_tready),
        .aw_addr (aw_addr), .aw_len (aw_len), .aw_valid (aw_valid),
        .w_data (w_data), .w_strb (w_strb), .w_last (w_last),
        .w_valid (w_valid), .w_ready (w_ready)
    );

    rdmx_checker u_rdmx_checker (
        .clk (clk), .resetn (resetn),
        .packet_size (packet_size), .frame_size (frame_size),
        .fd_ring_addr (fd_ring_addr), .fd_ring_size (fd_ring_size),
        .md_ring_addr (md_ring_addr), .md_ring_size (md_ring_size),
        .fc_addr (fc_addr),
        .fd_tready (fd_tready), .md_tready (md_tready),
        .aw_addr (aw_addr), .aw_len (aw_len), .aw_valid (aw_valid),
        .w_data (w_data), .w_strb (w_strb), .w_last (w_last),
        .w_valid (w_valid), .w_ready (w_ready),
        .all_seen (chk_done), .n_pass (n_pass), .n_fail (n_fail)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Run limit
    // --------------------------------------------------
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic add_test(input int i, input string name, input int pkt, input int frm,
                            input int fd_sz, input int md_sz, input int halves,
                            input bit holes);
        t_name[i]   = name;
        t_pkt[i]    = pkt;
        t_frm[i]    = frm;
        t_fd_sz[i]  = fd_sz;
        t_md_sz[i]  = md_sz;
        t_halves[i] = halves;
        t_holes[i]  = holes;
    endtask

    // --------------------------------------------------
    // Stream drivers, all stepping 1 ns after the rising edge
    // --------------------------------------------------
    task automatic feed_frame_data(input int halves, input int pkts_half, input int bpp,
                                   input bit holes);
        int  total;
        int  idx;
        bit  hs;
        total = halves * pkts_half * bpp;
        idx   = 0;
        while (idx < total) begin
            fd_tdata = u_rdmx_checker.fd_word(idx / (pkts_half * bpp),
                                              (idx / bpp) % pkts_half, idx % bpp);
            fd_tlast = ((idx % bpp) == bpp - 1);
            // Once offered, a beat stays valid until taken
            if (!fd_tvalid) begin
                fd_tvalid = holes ? ($urandom % 4 != 0) : 1'b1;
            end
            @(negedge clk);
            hs = fd_tvalid & fd_tready;
            @(posedge clk);
            #1;
            if (hs) begin
                idx++;
                fd_tvalid = 1'b0;
            end
        end
    endtask

    task automatic feed_metadata(input int halves, input bit holes);
        int  idx;
        bit  hs;
        idx = 0;
        // Two words per half frame
        while (idx < 2 * halves) begin
            md_tdata = u_rdmx_checker.md_word(idx / 2, idx % 2);
            if (!md_tvalid) begin
                md_tvalid = holes ? ($urandom % 2 != 0) : 1'b1;
            end
            @(negedge clk);
            hs = md_tvalid & md_tready;
            @(posedge clk);
            #1;
            if (hs) begin
                idx++;
                md_tvalid = 1'b0;
            end
        end
    endtask

    task automatic drive_ready(input bit holes);
        while (!chk_done) begin
            w_ready = holes ? ($urandom % 4 != 0) : 1'b1;
            @(posedge clk);
            #1;
        end
        w_ready = 1'b1;
    endtask

    // Reset for 8 cycles, then run one table entry to completion
    task automatic run_test(input int i);
        int pkts_half;
        int bpp;
        pkts_half = t_frm[i] / t_pkt[i] / 2;
        bpp       = t_pkt[i] / 8;
        u_rdmx_checker.start_test(t_name[i], t_halves[i]);
        resetn       = 1'b0;
        packet_size  = t_pkt[i];
        frame_size   = t_frm[i];
        fd_ring_size = t_fd_sz[i];
        md_ring_size = t_md_sz[i];
        // Upstream offers data and memory accepts while the shim is in reset
        fd_tvalid    = 1'b1;
        md_tvalid    = 1'b0;
        w_ready      = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        resetn    = 1'b1;
        fd_tvalid = 1'b0;
        fork
            feed_frame_data(t_halves[i], pkts_half, bpp, t_holes[i]);
            feed_metadata(t_halves[i], t_holes[i]);
            drive_ready(t_holes[i]);
        join
        // Idle tail catches stray beats
        repeat (4) @(posedge clk);
        #1;
        u_rdmx_checker.end_test();
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        resetn       = 1'b0;
        packet_size  = 16'd64;
        frame_size   = 32'd512;
        fd_ring_addr = 64'h0000_0004_1000_0000;
        fd_ring_size = 64'd4096;
        md_ring_addr = 64'h0000_0004_2000_0000;
        md_ring_size = 64'd1024;
        fc_addr      = 64'h0000_0004_3000_0080;
        fd_tdata     = '0;
        fd_tvalid    = 1'b0;
        fd_tlast     = 1'b0;
        md_tdata     = '0;
        md_tvalid    = 1'b0;
        w_ready      = 1'b0;
        seed         = $urandom(32'h59af);

        //       name              pkt  frame fd_ring md_ring halves holes
        add_test(0, "reset_state",     64,  512, 4096, 1024, 0, 1'b0);
        add_test(1, "fd_placement",    64,  512, 4096, 1024, 1, 1'b0);
        add_test(2, "md_fc_insert",    64,  512, 4096, 1024, 3, 1'b0);
        add_test(3, "ring_wrap",       64,  256,  200,   40, 6, 1'b0);
        add_test(4, "backpressure_64", 64,  512,  512,   64, 4, 1'b1);
        add_test(5, "backpressure_128", 128, 1024, 1024, 64, 3, 1'b1);

        // Frame data, two metadata beats and one counter beat per half frame
        total_beats = 0;
        for (ti = 0; ti < num_tests; ti++) begin
            total_beats += t_halves[ti] * ((t_frm[ti] / t_pkt[ti] / 2) * (t_pkt[ti] / 8) + 3);
        end
        limit = 8 * total_beats + 200;

        @(posedge clk);
        #1;
        for (ti = 0; ti < num_tests; ti++) begin
            run_test(ti);
        end

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rtl/rdmx_pkg.sv
rtl/md_capture.sv
rtl/frame_sequencer.sv
rtl/ring_addr_gen.sv
rtl/write_mux.sv
rtl/rdmx_shim_top.sv
tb/rdmx_checker.sv
tb/tb_rdmx_shim.sv
